//--- sources.f
hdl/uart_pkg.sv
hdl/uart_bit_timer.sv
hdl/uart_cmd_tx.sv
hdl/uart_byte_rx.sv
hdl/uart_cmd_link.sv
test/uart_line_bfm.sv
test/tb_uart_cmd_link.sv

//--- test/tb_uart_cmd_link.sv
`timescale 1ns/1ns

module tb_uart_cmd_link;
   import uart_pkg::*;

   localparam int CLKS_PER_BIT = 8;
   localparam int TIMEOUT = 40 * CLKS_PER_BIT; // cycles in 40 bit periods

   logic      clk = 1'b0;
   logic      rst_n;
   cmd_word_t cmd_in;
   logic      cmd_vld;
   logic      cmd_rdy;
   logic      tx;
   logic      rx;
   byte_t     read_data;
   logic      read_rdy;
   logic      parity_err;
   logic      frame_err;

   byte_t exp_tx[$];
   int    exp_rx_kind[$]; // 0 good byte, 1 parity error, 2 framing error
   byte_t exp_rx_data[$];
   byte_t last_good = '0;
   int    errors = 0;
   int    errors_at_start = 0;
   int    tests_run = 0;

   uart_cmd_link #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (.*);

   uart_line_bfm #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_line (.clk(clk), .tx(tx), .rx(rx));

   always #5 clk = ~clk;

   function automatic void expect_tx_bytes(input cmd_word_t cmd);
      exp_tx.push_back(cmd[15:8]); // high byte leaves first
      exp_tx.push_back(cmd[7:0]);
   endfunction

   task automatic check_byte(input string what, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         $display("FAILED %0t: %s is %02h, expected %02h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_cmd_rdy_wait(input int got, input int exp);
      if (got != exp) begin
         $display("FAILED %0t: cmd_rdy came back after %0d cycles, expected %0d",
                  $time, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("test %0d %s: %s", tests_run, name,
               (errors == errors_at_start) ? "ok" : "mismatch");
      errors_at_start = errors;
   endtask

   task automatic finish_run();
      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timeout at %0t: the DUT never answered while waiting for %s", $time, what);
      errors++;
      finish_run();
   endtask

   task automatic wait_cmd_rdy(inout int n);
      while (cmd_rdy !== 1'b1) begin
         if (n > TIMEOUT) begin
            abort_on_timeout("cmd_rdy");
         end
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   // cycles are counted from the one that presents the command
   task automatic send_cmd(input cmd_word_t cmd, output int n);
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
      n = 1;
      wait_cmd_rdy(n);
   endtask

   task automatic compare_tx();
      logic [9:0] f;
      byte_t      e;
      int         n;
      n = 0;
      while (u_line.tx_frames.size() < exp_tx.size()) begin
         if (n > TIMEOUT) begin
            abort_on_timeout("frames on tx");
         end
         @(posedge clk);
         #1;
         n++;
      end
      repeat (12 * CLKS_PER_BIT) @(posedge clk); // long enough to decode one more frame
      #1;
      if (u_line.tx_frames.size() != exp_tx.size()) begin
         $display("tx carried %0d frames where %0d were expected",
                  u_line.tx_frames.size(), exp_tx.size());
         errors++;
      end
      while (exp_tx.size() > 0 && u_line.tx_frames.size() > 0) begin
         f = u_line.tx_frames.pop_front();
         e = exp_tx.pop_front();
         check_byte("tx data byte", f[7:0], e);
         check_bit("tx parity bit", f[8], u_line.parity_to_make_odd(e));
         check_bit("tx stop bit", f[9], 1'b1);
      end
      exp_tx.delete();
      u_line.tx_frames.delete();
   endtask

   task automatic send_rx(input byte_t data, input int kind);
      int n;
      n = 0;
      exp_rx_kind.push_back(kind);
      exp_rx_data.push_back((kind == 0) ? data : last_good); // bad bytes leave it alone
      if (kind == 0) begin
         last_good = data;
      end
      u_line.send_frame(data, kind == 1, kind == 2);
      while (exp_rx_kind.size() > 0) begin
         if (n > TIMEOUT) begin
            abort_on_timeout("a receive pulse");
         end
         @(posedge clk);
         #1;
         n++;
      end
   endtask

   // every receive pulse is matched against the oldest outstanding frame
   always @(negedge clk) begin
      int    kind;
      byte_t data;
      if (read_rdy || parity_err || frame_err) begin
         if (exp_rx_kind.size() == 0) begin
            $display("receiver pulsed at %0t with no frame outstanding", $time);
            errors++;
         end else begin
            kind = exp_rx_kind.pop_front();
            data = exp_rx_data.pop_front();
            check_bit("read_rdy", read_rdy, kind == 0);
            check_bit("parity_err", parity_err, kind == 1);
            check_bit("frame_err", frame_err, kind == 2);
            check_byte("read_data", read_data, data);
         end
      end
   end

   initial begin
      cmd_word_t cmd;
      int        cycles;
      void'($urandom(32'hfb8f_a7b5));
      rst_n   = 1'b0;
      cmd_in  = '0;
      cmd_vld = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check_bit("tx after reset", tx, 1'b1);
      check_bit("cmd_rdy after reset", cmd_rdy, 1'b1);
      check_bit("read_rdy after reset", read_rdy, 1'b0);
      check_bit("parity_err after reset", parity_err, 1'b0);
      check_bit("frame_err after reset", frame_err, 1'b0);
      check_byte("read_data after reset", read_data, 8'h00);
      end_test("reset values");

      cmd = cmd_word_t'($urandom);
      expect_tx_bytes(cmd);
      send_cmd(cmd, cycles);
      check_cmd_rdy_wait(cycles, 22 * CLKS_PER_BIT + 1);
      compare_tx();
      end_test("single command");

      cmd = cmd_word_t'($urandom);
      expect_tx_bytes(cmd);
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_in = ~cmd; // arrives while busy and is dropped
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
      cycles  = 2;
      wait_cmd_rdy(cycles);
      for (int i = 0; i < 20; i++) begin
         cmd = cmd_word_t'($urandom);
         expect_tx_bytes(cmd);
         send_cmd(cmd, cycles);
      end
      compare_tx();
      end_test("back-pressure and command stream");

      for (int i = 0; i < 30; i++) begin
         send_rx(byte_t'($urandom), 0);
      end
      end_test("good receive bytes");

      send_rx(byte_t'($urandom), 1);
      end_test("parity error");

      send_rx(byte_t'($urandom), 2);
      repeat (2 * CLKS_PER_BIT) @(posedge clk); // the low stop bit looks like a false start
      #1;
      send_rx(byte_t'($urandom), 0);
      end_test("framing error and recovery");

      finish_run();
   end

endmodule

//--- test/uart_line_bfm.sv
`timescale 1ns/1ns

module uart_line_bfm #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic clk,
   input  logic tx,
   output logic rx
);
   import uart_pkg::*;

   logic [9:0] tx_frames[$]; // {stop, parity, data} of every frame seen on tx

   initial begin
      rx = 1'b1;
   end

   // parity bit that leaves an odd number of ones over data and parity
   function automatic logic parity_to_make_odd(input byte_t data);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         ones += data[i];
      end
      return (ones % 2) == 0;
   endfunction

   // one frame on rx, every bit starting 1 ns after a rising edge
   task automatic send_frame(input byte_t data, input logic corrupt_parity,
                             input logic bad_stop);
      logic [10:0] bits;
      bits = {~bad_stop, parity_to_make_odd(data) ^ corrupt_parity, data, 1'b0};
      @(posedge clk);
      for (int i = 0; i < 11; i++) begin
         #1;
         rx = bits[i];
         repeat (CLKS_PER_BIT) @(posedge clk);
      end
      #1;
      rx = 1'b1; // back to idle after a low stop bit
   endtask

   initial begin : tx_monitor
      logic [9:0] frame;
      forever begin
         @(negedge clk);
         if (tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk); // centre of the start bit
            for (int i = 0; i < 10; i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk);
               frame[i] = tx;
            end
            tx_frames.push_back(frame);
         end
      end
   end

endmodule

//--- hdl/uart_cmd_link.sv
`timescale 1ns/1ns

module uart_cmd_link #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                clk,
   input  logic                rst_n,
   input  uart_pkg::cmd_word_t cmd_in,
   input  logic                cmd_vld,
   output logic                cmd_rdy,
   output logic                tx,
   input  logic                rx,
   output uart_pkg::byte_t     read_data,
   output logic                read_rdy,
   output logic                parity_err,
   output logic                frame_err
);

   logic tx_bit_start;
   logic tx_bit_done;
   logic rx_bit_start;
   logic rx_half;
   logic rx_bit_stop;
   logic rx_bit_tick;

   uart_cmd_tx u_tx (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .bit_start (tx_bit_start),
      .bit_tick  (tx_bit_done),
      .tx        (tx)
   );

   // the transmit side always counts full periods and never halts
   uart_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx_timer (
      .clk   (clk),
      .rst_n (rst_n),
      .start (tx_bit_start),
      .half  (1'b0),
      .stop  (1'b0),
      .tick  (tx_bit_done)
   );

   uart_byte_rx u_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .bit_start  (rx_bit_start),
      .half       (rx_half),
      .bit_stop   (rx_bit_stop),
      .bit_tick   (rx_bit_tick),
      .read_data  (read_data),
      .read_rdy   (read_rdy),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

   uart_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx_timer (
      .clk   (clk),
      .rst_n (rst_n),
      .start (rx_bit_start),
      .half  (rx_half),
      .stop  (rx_bit_stop),
      .tick  (rx_bit_tick)
   );

endmodule

//--- hdl/uart_byte_rx.sv
`timescale 1ns/1ns

module uart_byte_rx (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            rx,
   output logic            bit_start,
   output logic            half,
   output logic            bit_stop,
   input  logic            bit_tick,
   output uart_pkg::byte_t read_data,
   output logic            read_rdy,
   output logic            parity_err,
   output logic            frame_err
);
   import uart_pkg::*;

   localparam logic [2:0] LAST_BIT = 3'(DATA_BITS - 1);

   rx_state_e  state;
   logic       rx_meta;
   logic       rx_sync;
   byte_t      shift_q;
   logic       par_bad_q;
   logic [2:0] bit_idx;
   logic       start_edge;

   assign start_edge = (state == RX_IDLE) && !rx_sync;
   assign bit_start  = start_edge;
   assign half       = start_edge; // first sample lands mid start bit

   // halt the timer on a false start and after the stop bit
   assign bit_stop = bit_tick &&
                     (((state == RX_START) && rx_sync) || (state == RX_STOP));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk) begin
      if ((state == RX_DATA) && bit_tick) begin
         shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]}; // lsb arrives first
      end
      if ((state == RX_PARITY) && bit_tick) begin
         par_bad_q <= (rx_sync != odd_parity(shift_q));
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= RX_IDLE;
         bit_idx    <= '0;
         read_data  <= '0;
         read_rdy   <= 1'b0;
         parity_err <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         read_rdy   <= 1'b0;
         parity_err <= 1'b0;
         frame_err  <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (start_edge) begin
                  state <= RX_START;
               end
            end

            RX_START: begin
               if (bit_tick) begin
                  bit_idx <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA; // glitch, not a start bit
               end
            end

            RX_DATA: begin
               if (bit_tick) begin
                  if (bit_idx == LAST_BIT) begin
                     state <= RX_PARITY;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                  end
               end
            end

            RX_PARITY: begin
               if (bit_tick) begin
                  state <= RX_STOP;
               end
            end

            RX_STOP: begin
               if (bit_tick) begin
                  state <= RX_IDLE;
                  if (par_bad_q) begin
                     parity_err <= 1'b1; // wins over a bad stop bit
                  end else if (!rx_sync) begin
                     frame_err <= 1'b1;
                  end else begin
                     read_rdy  <= 1'b1;
                     read_data <= shift_q;
                  end
               end
            end

            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hdl/uart_cmd_tx.sv
`timescale 1ns/1ns

module uart_cmd_tx (
   input  logic                clk,
   input  logic                rst_n,
   input  uart_pkg::cmd_word_t cmd_in,
   input  logic                cmd_vld,
   output logic                cmd_rdy,
   output logic                bit_start,
   input  logic                bit_tick,
   output logic                tx
);
   import uart_pkg::*;

   localparam logic [2:0] LAST_BIT = 3'(DATA_BITS - 1);

   tx_state_e  state;
   cmd_word_t  cmd_q;
   logic       byte_hi;
   logic [2:0] bit_idx;
   byte_t      cur_byte;
   logic       accept;

   assign cmd_rdy  = (state == TX_IDLE);
   assign accept   = cmd_vld && cmd_rdy; // cmd_vld outside idle is dropped
   assign cur_byte = byte_hi ? cmd_q[DATA_BITS +: DATA_BITS] : cmd_q[0 +: DATA_BITS];

   // restart the period on every bit boundary except after the final stop bit
   assign bit_start = accept ||
                      (bit_tick && (state != TX_IDLE) && (state != TX_STOP));

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= cmd_in;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= TX_IDLE;
         byte_hi <= 1'b0;
         bit_idx <= '0;
         tx      <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               if (accept) begin
                  byte_hi <= 1'b1;
                  tx      <= 1'b0; // start bit of the high byte
                  state   <= TX_START;
               end
            end

            TX_START: begin
               if (bit_tick) begin
                  bit_idx <= '0;
                  tx      <= cur_byte[0];
                  state   <= TX_DATA;
               end
            end

            TX_DATA: begin
               if (bit_tick) begin
                  if (bit_idx == LAST_BIT) begin
                     tx    <= odd_parity(cur_byte);
                     state <= TX_PARITY;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                     tx      <= cur_byte[bit_idx + 3'd1];
                  end
               end
            end

            TX_PARITY: begin
               if (bit_tick) begin
                  tx    <= 1'b1;
                  state <= byte_hi ? TX_GAP : TX_STOP;
               end
            end

            TX_GAP: begin
               if (bit_tick) begin
                  byte_hi <= 1'b0;
                  tx      <= 1'b0; // low byte starts with no idle bit between
                  state   <= TX_START;
               end
            end

            TX_STOP: begin
               if (bit_tick) begin
                  state <= TX_IDLE;
               end
            end

            default: begin
               tx    <= 1'b1;
               state <= TX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hdl/uart_bit_timer.sv
`timescale 1ns/1ns

module uart_bit_timer #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic half,
   input  logic stop,
   output logic tick
);

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] FULL_LOAD = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF_LOAD = CW'(CLKS_PER_BIT / 2 - 1);

   logic [CW-1:0] cnt;
   logic          running;

   assign tick = running && (cnt == '0); // last cycle of the period

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt     <= '0;
         running <= 1'b0;
      end else if (start) begin
         cnt     <= half ? HALF_LOAD : FULL_LOAD; // half period centres the samples
         running <= 1'b1;
      end else if (stop) begin
         cnt     <= '0;
         running <= 1'b0;
      end else if (running) begin
         if (cnt == '0) begin
            cnt <= FULL_LOAD;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

   localparam int DATA_BITS = 8;

   typedef logic [DATA_BITS-1:0]   byte_t;
   typedef logic [2*DATA_BITS-1:0] cmd_word_t; // high byte goes out first

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_PARITY,
      TX_STOP,
      TX_GAP // stop bit of the high byte, then straight on to the low byte
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_e;

   // bit that makes the total count of ones odd
   function automatic logic odd_parity(input byte_t data);
      return ~^data;
   endfunction

endpackage
